//--- alu.sv
`timescale 1ns/1ps

module alu (
	input cpu_pkg::alu_op_t op,
	input logic [cpu_pkg::XLEN-1:0] a,
	input logic [cpu_pkg::XLEN-1:0] b,
	output logic [cpu_pkg::XLEN-1:0] y
);

	// Shift amount from the low bits of b
	logic [$clog2(cpu_pkg::XLEN)-1:0] shamt;

	assign shamt = b[$clog2(cpu_pkg::XLEN)-1:0];

	always_comb begin
		case (op)
			cpu_pkg::ALU_ADD: begin
				y = a + b;
			end
			cpu_pkg::ALU_SUB: begin
				y = a - b;
			end
			cpu_pkg::ALU_AND: begin
				y = a & b;
			end
			cpu_pkg::ALU_OR: begin
				y = a | b;
			end
			cpu_pkg::ALU_XOR: begin
				y = a ^ b;
			end
			cpu_pkg::ALU_SLL: begin
				y = a << shamt;
			end
			// Logical, zero fill
			cpu_pkg::ALU_SRL: begin
				y = a >> shamt;
			end
			// Undefined func codes give zero
			default: begin
				y = '0;
			end
		endcase
	end

endmodule

//--- cpu_pkg.sv
package cpu_pkg;

	// Datapath and instruction width
	localparam int XLEN = 16;

	// Register file geometry
	localparam int REG_COUNT = 16;
	localparam int REG_AW = 4;

	// Program memory holds 256 words
	localparam int IMEM_AW = 8;

	// Data memory holds 16 words
	localparam int DMEM_AW = 4;

	// Opcode field
	localparam int OPC_MSB = 15;
	localparam int OPC_LSB = 12;

	// Destination register field, also first source
	localparam int RD_MSB = 11;
	localparam int RD_LSB = 8;

	// Second source register field
	localparam int RS_MSB = 7;
	localparam int RS_LSB = 4;

	// Func code or 4-bit immediate
	localparam int FN_MSB = 3;
	localparam int FN_LSB = 0;

	// Top bit of the load-immediate byte
	localparam int IMM8_MSB = 7;

	// Top bit of the jump offset
	localparam int JOFF_MSB = 11;

	// Codes 8 to 15 are no-operations
	typedef enum logic [3:0] {
		OP_ALU  = 4'd0,
		OP_ADDI = 4'd1,
		OP_LI   = 4'd2,
		OP_LW   = 4'd3,
		OP_SW   = 4'd4,
		OP_BEQ  = 4'd5,
		OP_JMP  = 4'd6,
		OP_HALT = 4'd7
	} opcode_t;

	// Carried directly in the func field of OP_ALU
	typedef enum logic [3:0] {
		ALU_ADD = 4'd0,
		ALU_SUB = 4'd1,
		ALU_AND = 4'd2,
		ALU_OR  = 4'd3,
		ALU_XOR = 4'd4,
		ALU_SLL = 4'd5,
		ALU_SRL = 4'd6
	} alu_op_t;

	// Operand source select
	typedef enum logic [1:0] {
		FWD_REG = 2'd0,
		FWD_S2  = 2'd1,
		FWD_S3  = 2'd2
	} fwd_sel_t;

endpackage

//--- cpu_top.f
cpu_pkg.sv
pipe_ifs.sv
fetch_unit.sv
reg_file.sv
hazard_unit.sv
decode_stage.sv
alu.sv
exec_mem_stage.sv
cpu_top.sv
cpu_top_asserts.sv
tb_cpu_top.sv

//--- cpu_top.sv
`timescale 1ns/1ps

module cpu_top (
	input logic clk,
	input logic reset,
	input logic prog_we,
	input logic [cpu_pkg::IMEM_AW-1:0] prog_addr,
	input logic [cpu_pkg::XLEN-1:0] prog_data,
	output logic halted,
	output logic wb_en,
	output logic [cpu_pkg::REG_AW-1:0] wb_rd,
	output logic [cpu_pkg::XLEN-1:0] wb_data,
	output logic dmem_we,
	output logic [cpu_pkg::DMEM_AW-1:0] dmem_addr,
	output logic [cpu_pkg::XLEN-1:0] dmem_wdata
);

	// Fetch to decode
	logic [cpu_pkg::XLEN-1:0] pc;
	logic [cpu_pkg::XLEN-1:0] instr;
	// Decode back to fetch
	logic branch_taken;
	logic [cpu_pkg::XLEN-1:0] branch_target;
	logic halt_seen;
	// Register file read side
	logic [cpu_pkg::REG_AW-1:0] ra1;
	logic [cpu_pkg::REG_AW-1:0] ra2;
	logic [cpu_pkg::XLEN-1:0] rd1;
	logic [cpu_pkg::XLEN-1:0] rd2;
	// Hazard inputs and decisions
	logic [cpu_pkg::REG_AW-1:0] rs_a;
	logic [cpu_pkg::REG_AW-1:0] rs_b;
	logic uses_a;
	logic uses_b;
	logic stall;
	cpu_pkg::fwd_sel_t fwd_a;
	cpu_pkg::fwd_sel_t fwd_b;

	stage_if s12 ();
	fwd_if fwd ();

	fetch_unit fetch0 (
		.clk(clk),
		.reset(reset),
		.prog_we(prog_we),
		.prog_addr(prog_addr),
		.prog_data(prog_data),
		.stall(stall),
		.halt_seen(halt_seen),
		.branch_taken(branch_taken),
		.branch_target(branch_target),
		.pc(pc),
		.instr(instr)
	);

	decode_stage decode0 (
		.clk(clk),
		.reset(reset),
		.pc(pc),
		.instr(instr),
		.stall(stall),
		.fwd_a(fwd_a),
		.fwd_b(fwd_b),
		.fw(fwd.sink),
		.st(s12.producer),
		.branch_taken(branch_taken),
		.branch_target(branch_target),
		.halt_seen(halt_seen),
		.ra1(ra1),
		.ra2(ra2),
		.rs_a(rs_a),
		.rs_b(rs_b),
		.uses_a(uses_a),
		.uses_b(uses_b),
		.rd1(rd1),
		.rd2(rd2)
	);

	// Written from stage 3 write-back
	reg_file regs0 (
		.clk(clk),
		.reset(reset),
		.ra1(ra1),
		.ra2(ra2),
		.wb_en(wb_en),
		.wb_rd(wb_rd),
		.wb_data(wb_data),
		.rd1(rd1),
		.rd2(rd2)
	);

	hazard_unit hazard0 (
		.rs_a(rs_a),
		.rs_b(rs_b),
		.uses_a(uses_a),
		.uses_b(uses_b),
		.st(s12.monitor),
		.fw(fwd.sink),
		.stall(stall),
		.fwd_a(fwd_a),
		.fwd_b(fwd_b)
	);

	// ALU, data memory and retirement trace
	exec_mem_stage exmem0 (
		.clk(clk),
		.reset(reset),
		.st(s12.consumer),
		.fw(fwd.source),
		.wb_en(wb_en),
		.wb_rd(wb_rd),
		.wb_data(wb_data),
		.dmem_we(dmem_we),
		.dmem_addr(dmem_addr),
		.dmem_wdata(dmem_wdata),
		.halted(halted)
	);

endmodule

//--- cpu_top_asserts.sv
`timescale 1ns/1ps

module cpu_top_asserts (
	input logic clk,
	input logic reset,
	input logic wb_en,
	input logic dmem_we,
	input logic halted
);

	// Number of assertion failures so far
	int fail_count = 0;

	// Stage 3 retires a register write or a store, never both
	wb_vs_store: assert property (@(posedge clk) disable iff (reset)
		!(wb_en && dmem_we))
		else begin
			fail_count++;
			$error("wb_en and dmem_we high in the same cycle");
		end

	// Sticky until the next reset
	halted_holds: assert property (@(posedge clk) disable iff (reset)
		halted |=> halted)
		else begin
			fail_count++;
			$error("halted fell while reset was low");
		end

	// Only bubbles drain after the halt
	quiet_after_halt: assert property (@(posedge clk) disable iff (reset)
		halted |-> (!wb_en && !dmem_we))
		else begin
			fail_count++;
			$error("write-back or store seen after halted");
		end

endmodule

//--- decode_stage.sv
`timescale 1ns/1ps

module decode_stage (
	input logic clk,
	input logic reset,
	input logic [cpu_pkg::XLEN-1:0] pc,
	input logic [cpu_pkg::XLEN-1:0] instr,
	input logic stall,
	input cpu_pkg::fwd_sel_t fwd_a,
	input cpu_pkg::fwd_sel_t fwd_b,
	fwd_if.sink fw,
	stage_if.producer st,
	output logic branch_taken,
	output logic [cpu_pkg::XLEN-1:0] branch_target,
	output logic halt_seen,
	output logic [cpu_pkg::REG_AW-1:0] ra1,
	output logic [cpu_pkg::REG_AW-1:0] ra2,
	output logic [cpu_pkg::REG_AW-1:0] rs_a,
	output logic [cpu_pkg::REG_AW-1:0] rs_b,
	output logic uses_a,
	output logic uses_b,
	input logic [cpu_pkg::XLEN-1:0] rd1,
	input logic [cpu_pkg::XLEN-1:0] rd2
);

	cpu_pkg::opcode_t op;
	logic [cpu_pkg::REG_AW-1:0] rd_f;
	logic [cpu_pkg::REG_AW-1:0] rs_f;
	logic [cpu_pkg::FN_MSB-cpu_pkg::FN_LSB:0] imm4;
	logic [cpu_pkg::XLEN-1:0] imm4_sx;
	logic [cpu_pkg::XLEN-1:0] imm8_sx;
	logic [cpu_pkg::XLEN-1:0] joff_sx;
	logic [cpu_pkg::XLEN-1:0] pc_inc;
	// Forwarded values of the rd and rs fields
	logic [cpu_pkg::XLEN-1:0] opa;
	logic [cpu_pkg::XLEN-1:0] opb;
	// Halt already sent down the pipe
	logic halt_done;
	cpu_pkg::alu_op_t n_op;
	logic [cpu_pkg::XLEN-1:0] n_a;
	logic [cpu_pkg::XLEN-1:0] n_b;
	logic n_reg_wr;
	logic n_mem_rd;
	logic n_mem_wr;
	logic n_halt;

	function automatic logic [cpu_pkg::XLEN-1:0] fwd_mux(
		input cpu_pkg::fwd_sel_t sel,
		input logic [cpu_pkg::XLEN-1:0] reg_val,
		input logic [cpu_pkg::XLEN-1:0] s2_val,
		input logic [cpu_pkg::XLEN-1:0] s3_val
	);
		case (sel)
			cpu_pkg::FWD_S2: return s2_val;
			cpu_pkg::FWD_S3: return s3_val;
			default: return reg_val;
		endcase
	endfunction

	// Field split
	assign op = cpu_pkg::opcode_t'(instr[cpu_pkg::OPC_MSB:cpu_pkg::OPC_LSB]);
	assign rd_f = instr[cpu_pkg::RD_MSB:cpu_pkg::RD_LSB];
	assign rs_f = instr[cpu_pkg::RS_MSB:cpu_pkg::RS_LSB];
	assign imm4 = instr[cpu_pkg::FN_MSB:cpu_pkg::FN_LSB];

	// Sign extension of the three immediate sizes
	assign imm4_sx = cpu_pkg::XLEN'($signed(imm4));
	assign imm8_sx = cpu_pkg::XLEN'($signed(instr[cpu_pkg::IMM8_MSB:0]));
	assign joff_sx = cpu_pkg::XLEN'($signed(instr[cpu_pkg::JOFF_MSB:0]));

	// Port 1 reads rd, port 2 reads rs
	assign ra1 = rd_f;
	assign ra2 = rs_f;
	assign rs_a = rd_f;
	assign rs_b = rs_f;

	assign opa = fwd_mux(fwd_a, rd1, fw.s2_result, fw.s3_data);
	assign opb = fwd_mux(fwd_b, rd2, fw.s2_result, fw.s3_data);

	// Branches resolve here, so nothing behind them needs flushing
	assign pc_inc = pc + cpu_pkg::XLEN'(1);
	assign branch_target = (op == cpu_pkg::OP_JMP) ? pc_inc + joff_sx : pc_inc + imm4_sx;
	assign branch_taken = (op == cpu_pkg::OP_JMP) || ((op == cpu_pkg::OP_BEQ) && (opa == opb));
	assign halt_seen = (op == cpu_pkg::OP_HALT);

	// Decoder and operand build
	always_comb begin
		n_op = cpu_pkg::ALU_ADD;
		n_a = opa;
		n_b = opb;
		n_reg_wr = 1'b0;
		n_mem_rd = 1'b0;
		n_mem_wr = 1'b0;
		n_halt = 1'b0;
		uses_a = 1'b0;
		uses_b = 1'b0;
		case (op)
			cpu_pkg::OP_ALU: begin
				// rd = rd op rs
				n_op = cpu_pkg::alu_op_t'(imm4);
				n_reg_wr = 1'b1;
				uses_a = 1'b1;
				uses_b = 1'b1;
			end
			cpu_pkg::OP_ADDI: begin
				n_a = opb;
				n_b = imm4_sx;
				n_reg_wr = 1'b1;
				uses_b = 1'b1;
			end
			cpu_pkg::OP_LI: begin
				n_a = '0;
				n_b = imm8_sx;
				n_reg_wr = 1'b1;
			end
			cpu_pkg::OP_LW: begin
				// Address is rs plus offset
				n_a = opb;
				n_b = imm4_sx;
				n_reg_wr = 1'b1;
				n_mem_rd = 1'b1;
				uses_b = 1'b1;
			end
			cpu_pkg::OP_SW: begin
				n_a = opb;
				n_b = imm4_sx;
				n_mem_wr = 1'b1;
				uses_a = 1'b1;
				uses_b = 1'b1;
			end
			cpu_pkg::OP_BEQ: begin
				// Comparator needs both, even though nothing is written
				uses_a = 1'b1;
				uses_b = 1'b1;
			end
			cpu_pkg::OP_HALT: begin
				n_halt = 1'b1;
			end
			default: begin
				// Jump and unused codes pass as no-ops
				n_halt = 1'b0;
			end
		endcase
	end

	// Control half of the stage register
	always_ff @(posedge clk) begin
		if (reset) begin
			st.valid <= 1'b0;
			st.reg_wr <= 1'b0;
			st.mem_rd <= 1'b0;
			st.mem_wr <= 1'b0;
			st.halt <= 1'b0;
			halt_done <= 1'b0;
		end else begin
			// Bubble on stall and after the halt has gone
			st.valid <= !stall && !halt_done;
			st.reg_wr <= n_reg_wr;
			st.mem_rd <= n_mem_rd;
			st.mem_wr <= n_mem_wr;
			st.halt <= n_halt;
			if (!stall && n_halt) begin
				halt_done <= 1'b1;
			end
		end
	end

	// Payload half
	always_ff @(posedge clk) begin
		st.alu_op <= n_op;
		st.a <= n_a;
		st.b <= n_b;
		st.store_data <= opa;
		st.rd <= rd_f;
	end

endmodule

//--- exec_mem_stage.sv
`timescale 1ns/1ps

module exec_mem_stage (
	input logic clk,
	input logic reset,
	stage_if.consumer st,
	fwd_if.source fw,
	output logic wb_en,
	output logic [cpu_pkg::REG_AW-1:0] wb_rd,
	output logic [cpu_pkg::XLEN-1:0] wb_data,
	output logic dmem_we,
	output logic [cpu_pkg::DMEM_AW-1:0] dmem_addr,
	output logic [cpu_pkg::XLEN-1:0] dmem_wdata,
	output logic halted
);

	logic [cpu_pkg::XLEN-1:0] alu_y;
	// Stage 3 control
	logic s3_valid;
	logic s3_reg_wr;
	logic s3_mem_rd;
	logic s3_mem_wr;
	// Stage 3 payload
	logic [cpu_pkg::REG_AW-1:0] s3_rd;
	logic [cpu_pkg::XLEN-1:0] s3_result;
	logic [cpu_pkg::XLEN-1:0] s3_store;
	logic [cpu_pkg::XLEN-1:0] dmem [2**cpu_pkg::DMEM_AW];
	logic [cpu_pkg::XLEN-1:0] load_data;

	alu alu0 (
		.op(st.alu_op),
		.a(st.a),
		.b(st.b),
		.y(alu_y)
	);

	// Stage 2 view for forwarding and load-use detection
	assign fw.s2_wr = st.valid && st.reg_wr;
	assign fw.s2_rd = st.rd;
	assign fw.s2_is_load = st.valid && st.mem_rd;
	assign fw.s2_result = alu_y;

	always_ff @(posedge clk) begin
		if (reset) begin
			s3_valid <= 1'b0;
			s3_reg_wr <= 1'b0;
			s3_mem_rd <= 1'b0;
			s3_mem_wr <= 1'b0;
			halted <= 1'b0;
		end else begin
			s3_valid <= st.valid;
			s3_reg_wr <= st.reg_wr;
			s3_mem_rd <= st.mem_rd;
			s3_mem_wr <= st.mem_wr;
			// Sticky once the halt enters stage 3
			halted <= halted || (st.valid && st.halt);
		end
	end

	always_ff @(posedge clk) begin
		s3_rd <= st.rd;
		s3_result <= alu_y;
		s3_store <= st.store_data;
	end

	// Data memory, cleared by reset
	always_ff @(posedge clk) begin
		if (reset) begin
			for (int i = 0; i < 2**cpu_pkg::DMEM_AW; i++) begin
				dmem[i] <= '0;
			end
		end else if (dmem_we) begin
			dmem[dmem_addr] <= dmem_wdata;
		end
	end

	// ALU result doubles as the word address
	assign dmem_addr = s3_result[cpu_pkg::DMEM_AW-1:0];
	assign dmem_we = s3_valid && s3_mem_wr;
	assign dmem_wdata = s3_store;
	assign load_data = dmem[dmem_addr];

	// Write-back select
	assign wb_en = s3_valid && s3_reg_wr;
	assign wb_rd = s3_rd;
	assign wb_data = s3_mem_rd ? load_data : s3_result;

	// Same data feeds stage-3 forwarding
	assign fw.s3_wr = wb_en;
	assign fw.s3_rd = s3_rd;
	assign fw.s3_data = wb_data;

endmodule

//--- fetch_unit.sv
`timescale 1ns/1ps

module fetch_unit (
	input logic clk,
	input logic reset,
	input logic prog_we,
	input logic [cpu_pkg::IMEM_AW-1:0] prog_addr,
	input logic [cpu_pkg::XLEN-1:0] prog_data,
	input logic stall,
	input logic halt_seen,
	input logic branch_taken,
	input logic [cpu_pkg::XLEN-1:0] branch_target,
	output logic [cpu_pkg::XLEN-1:0] pc,
	output logic [cpu_pkg::XLEN-1:0] instr
);

	// Program store, no reset
	logic [cpu_pkg::XLEN-1:0] imem [2**cpu_pkg::IMEM_AW];
	logic [cpu_pkg::XLEN-1:0] pc_next;

	// Hold wins over branch, branch over increment
	always_comb begin
		if (stall || halt_seen) begin
			pc_next = pc;
		end else if (branch_taken) begin
			pc_next = branch_target;
		end else begin
			pc_next = pc + cpu_pkg::XLEN'(1);
		end
	end

	// Fetch starts at word 0 after reset
	always_ff @(posedge clk) begin
		if (reset) begin
			pc <= '0;
		end else begin
			pc <= pc_next;
		end
	end

	// Loader port, only open while in reset
	always_ff @(posedge clk) begin
		if (reset && prog_we) begin
			imem[prog_addr] <= prog_data;
		end
	end

	// Asynchronous read, upper PC bits wrap
	assign instr = imem[pc[cpu_pkg::IMEM_AW-1:0]];

endmodule

//--- hazard_unit.sv
`timescale 1ns/1ps

module hazard_unit (
	input logic [cpu_pkg::REG_AW-1:0] rs_a,
	input logic [cpu_pkg::REG_AW-1:0] rs_b,
	input logic uses_a,
	input logic uses_b,
	stage_if.monitor st,
	fwd_if.sink fw,
	output logic stall,
	output cpu_pkg::fwd_sel_t fwd_a,
	output cpu_pkg::fwd_sel_t fwd_b
);

	logic load_hit_a;
	logic load_hit_b;

	// Youngest producer wins
	function automatic cpu_pkg::fwd_sel_t pick_src(
		input logic [cpu_pkg::REG_AW-1:0] src,
		input logic s2_wr,
		input logic [cpu_pkg::REG_AW-1:0] s2_rd,
		input logic s3_wr,
		input logic [cpu_pkg::REG_AW-1:0] s3_rd
	);
		if (s2_wr && (s2_rd == src)) begin
			return cpu_pkg::FWD_S2;
		end else if (s3_wr && (s3_rd == src)) begin
			return cpu_pkg::FWD_S3;
		end
		return cpu_pkg::FWD_REG;
	endfunction

	assign fwd_a = pick_src(rs_a, fw.s2_wr, fw.s2_rd, fw.s3_wr, fw.s3_rd);
	assign fwd_b = pick_src(rs_b, fw.s2_wr, fw.s2_rd, fw.s3_wr, fw.s3_rd);

	// Load result only exists in stage 3
	assign load_hit_a = uses_a && (st.rd == rs_a);
	assign load_hit_b = uses_b && (st.rd == rs_b);

	// One bubble, then stage 3 forwards the loaded word
	assign stall = fw.s2_is_load && st.reg_wr && (load_hit_a || load_hit_b);

endmodule

//--- pipe_ifs.sv
`timescale 1ns/1ps

// Stage 1 to stage 2 bundle, all registered in decode
interface stage_if;
	logic valid;
	cpu_pkg::alu_op_t alu_op;
	logic [cpu_pkg::XLEN-1:0] a;
	logic [cpu_pkg::XLEN-1:0] b;
	logic [cpu_pkg::XLEN-1:0] store_data;
	logic [cpu_pkg::REG_AW-1:0] rd;
	logic reg_wr;
	logic mem_rd;
	logic mem_wr;
	logic halt;

	modport producer (output valid, alu_op, a, b, store_data, rd, reg_wr, mem_rd, mem_wr, halt);
	modport consumer (input valid, alu_op, a, b, store_data, rd, reg_wr, mem_rd, mem_wr, halt);
	// Hazard unit only needs the load destination
	modport monitor (input rd, reg_wr);
endinterface

// Results in flight from stage 2 and stage 3
interface fwd_if;
	logic s2_wr;
	logic [cpu_pkg::REG_AW-1:0] s2_rd;
	logic s2_is_load;
	logic [cpu_pkg::XLEN-1:0] s2_result;
	logic s3_wr;
	logic [cpu_pkg::REG_AW-1:0] s3_rd;
	logic [cpu_pkg::XLEN-1:0] s3_data;

	modport source (output s2_wr, s2_rd, s2_is_load, s2_result, s3_wr, s3_rd, s3_data);
	modport sink (input s2_wr, s2_rd, s2_is_load, s2_result, s3_wr, s3_rd, s3_data);
endinterface

//--- reg_file.sv
`timescale 1ns/1ps

module reg_file (
	input logic clk,
	input logic reset,
	input logic [cpu_pkg::REG_AW-1:0] ra1,
	input logic [cpu_pkg::REG_AW-1:0] ra2,
	input logic wb_en,
	input logic [cpu_pkg::REG_AW-1:0] wb_rd,
	input logic [cpu_pkg::XLEN-1:0] wb_data,
	output logic [cpu_pkg::XLEN-1:0] rd1,
	output logic [cpu_pkg::XLEN-1:0] rd2
);

	logic [cpu_pkg::XLEN-1:0] regs [cpu_pkg::REG_COUNT];

	// All registers come out of reset as zero
	always_ff @(posedge clk) begin
		if (reset) begin
			for (int i = 0; i < cpu_pkg::REG_COUNT; i++) begin
				regs[i] <= '0;
			end
		end else if (wb_en) begin
			regs[wb_rd] <= wb_data;
		end
	end

	// Old value on a same-cycle write
	// Stage-3 forwarding covers that case
	assign rd1 = regs[ra1];
	assign rd2 = regs[ra2];

endmodule

//--- run.sh
#!/bin/sh
# Build and run the cpu_top testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --assert --timescale 1ns/1ps \
	--top-module tb_cpu_top -f cpu_top.f -o sim_cpu_top
if [ $? -ne 0 ]; then
	echo "Verilator build failed"
	exit 1
fi

out=$(./obj_dir/sim_cpu_top)
status=$?
printf '%s\n' "$out"
if [ $status -ne 0 ]; then
	echo "Simulation exited with status $status"
	exit 1
fi

if printf '%s\n' "$out" | grep -qx "All checks passed"; then
	exit 0
fi
exit 1

//--- tb_cpu_top.sv
`timescale 1ns/1ps

module tb_cpu_top;

	localparam int PROG_LEN = 41;
	localparam int NUM_PROGS = 8;
	localparam int RESET_CYCLES = 8;
	localparam int HALT_TIMEOUT = 2000;
	localparam int STEP_LIMIT = 1000;

	logic clk = 1'b0;
	logic reset;
	logic prog_we;
	logic [cpu_pkg::IMEM_AW-1:0] prog_addr;
	logic [cpu_pkg::XLEN-1:0] prog_data;
	logic halted;
	logic wb_en;
	logic [cpu_pkg::REG_AW-1:0] wb_rd;
	logic [cpu_pkg::XLEN-1:0] wb_data;
	logic dmem_we;
	logic [cpu_pkg::DMEM_AW-1:0] dmem_addr;
	logic [cpu_pkg::XLEN-1:0] dmem_wdata;

	integer seed = 95;
	int errors = 0;
	int reg_checks = 0;
	int mem_checks = 0;
	string test_name;

	// Program image and instruction-level model state
	logic [cpu_pkg::XLEN-1:0] prog [2**cpu_pkg::IMEM_AW];
	logic [cpu_pkg::XLEN-1:0] m_regs [cpu_pkg::REG_COUNT];
	logic [cpu_pkg::XLEN-1:0] m_dmem [2**cpu_pkg::DMEM_AW];
	// Expected retirement trace, in program order
	logic [cpu_pkg::REG_AW-1:0] exp_rd [$];
	logic [cpu_pkg::XLEN-1:0] exp_rdata [$];
	logic [cpu_pkg::DMEM_AW-1:0] exp_maddr [$];
	logic [cpu_pkg::XLEN-1:0] exp_mdata [$];

	always #20 clk = ~clk;

	cpu_top dut0 (
		.clk(clk),
		.reset(reset),
		.prog_we(prog_we),
		.prog_addr(prog_addr),
		.prog_data(prog_data),
		.halted(halted),
		.wb_en(wb_en),
		.wb_rd(wb_rd),
		.wb_data(wb_data),
		.dmem_we(dmem_we),
		.dmem_addr(dmem_addr),
		.dmem_wdata(dmem_wdata)
	);

	// Assertions sit inside the stage-3 module
	bind exec_mem_stage cpu_top_asserts asrt0 (
		.clk(clk),
		.reset(reset),
		.wb_en(wb_en),
		.dmem_we(dmem_we),
		.halted(halted)
	);

	function automatic logic [31:0] next_rand();
		logic [31:0] r;
		r = $random(seed);
		return r;
	endfunction

	function automatic logic [cpu_pkg::XLEN-1:0] sext4(input logic [3:0] v);
		return {{(cpu_pkg::XLEN-4){v[3]}}, v};
	endfunction

	function automatic logic [cpu_pkg::XLEN-1:0] sext8(input logic [7:0] v);
		return {{(cpu_pkg::XLEN-8){v[7]}}, v};
	endfunction

	function automatic logic [cpu_pkg::XLEN-1:0] sext12(input logic [11:0] v);
		return {{(cpu_pkg::XLEN-12){v[11]}}, v};
	endfunction

	// Reference ALU, rd op rs
	function automatic logic [cpu_pkg::XLEN-1:0] alu_model(
		input logic [3:0] fn,
		input logic [cpu_pkg::XLEN-1:0] a,
		input logic [cpu_pkg::XLEN-1:0] b
	);
		case (fn)
			cpu_pkg::ALU_ADD: return a + b;
			cpu_pkg::ALU_SUB: return a - b;
			cpu_pkg::ALU_AND: return a & b;
			cpu_pkg::ALU_OR: return a | b;
			cpu_pkg::ALU_XOR: return a ^ b;
			cpu_pkg::ALU_SLL: return a << b[3:0];
			cpu_pkg::ALU_SRL: return a >> b[3:0];
			default: return '0;
		endcase
	endfunction

	// 40 random instructions, then halt
	task automatic build_program();
		logic [31:0] r;
		logic [cpu_pkg::IMEM_AW-1:0] idx;
		logic [cpu_pkg::REG_AW-1:0] rdf;
		logic [cpu_pkg::REG_AW-1:0] rsf;
		int sel;
		int off;
		int lim;
		for (idx = '0; int'(idx) < PROG_LEN - 1; idx++) begin
			sel = int'(next_rand() % 32'd20);
			r = next_rand();
			// Eight registers keep dependencies dense
			rdf = {1'b0, r[2:0]};
			rsf = {1'b0, r[6:4]};
			// Forward offsets that land no later than the halt
			lim = PROG_LEN - 2 - int'(idx);
			off = int'(r[10:8]);
			if (off > lim) begin
				off = lim;
			end
			if (sel < 6) begin
				prog[idx] = {cpu_pkg::OP_ALU, rdf, rsf, r[11:8] % 4'd7};
			end else if (sel < 9) begin
				prog[idx] = {cpu_pkg::OP_ADDI, rdf, rsf, r[11:8]};
			end else if (sel < 12) begin
				prog[idx] = {cpu_pkg::OP_LI, rdf, r[19:12]};
			end else if (sel < 14) begin
				prog[idx] = {cpu_pkg::OP_LW, rdf, rsf, r[11:8]};
			end else if (sel < 16) begin
				prog[idx] = {cpu_pkg::OP_SW, rdf, rsf, r[11:8]};
			end else if (sel < 18) begin
				prog[idx] = {cpu_pkg::OP_BEQ, rdf, rsf, 4'(off)};
			end else if (sel < 19) begin
				prog[idx] = {cpu_pkg::OP_JMP, 12'(off)};
			end else begin
				// Codes 8 to 15 do nothing
				prog[idx] = {1'b1, r[14:12], r[27:16]};
			end
		end
		prog[idx] = {cpu_pkg::OP_HALT, 12'h000};
	endtask

	// Runs the program one instruction at a time
	task automatic run_model();
		logic [cpu_pkg::XLEN-1:0] mpc;
		logic [cpu_pkg::XLEN-1:0] npc;
		logic [cpu_pkg::XLEN-1:0] w;
		logic [cpu_pkg::XLEN-1:0] ea;
		logic [cpu_pkg::XLEN-1:0] res;
		logic [3:0] op;
		logic [cpu_pkg::REG_AW-1:0] rdf;
		logic [cpu_pkg::REG_AW-1:0] rsf;
		logic [3:0] lo;
		logic done;
		int steps;
		exp_rd.delete();
		exp_rdata.delete();
		exp_maddr.delete();
		exp_mdata.delete();
		m_regs = '{default: '0};
		m_dmem = '{default: '0};
		mpc = '0;
		done = 1'b0;
		steps = 0;
		while (!done && steps < STEP_LIMIT) begin
			w = prog[mpc[cpu_pkg::IMEM_AW-1:0]];
			op = w[cpu_pkg::OPC_MSB:cpu_pkg::OPC_LSB];
			rdf = w[cpu_pkg::RD_MSB:cpu_pkg::RD_LSB];
			rsf = w[cpu_pkg::RS_MSB:cpu_pkg::RS_LSB];
			lo = w[cpu_pkg::FN_MSB:cpu_pkg::FN_LSB];
			npc = mpc + cpu_pkg::XLEN'(1);
			ea = m_regs[rsf] + sext4(lo);
			case (op)
				cpu_pkg::OP_ALU, cpu_pkg::OP_ADDI, cpu_pkg::OP_LI, cpu_pkg::OP_LW: begin
					if (op == cpu_pkg::OP_ALU) begin
						res = alu_model(lo, m_regs[rdf], m_regs[rsf]);
					end else if (op == cpu_pkg::OP_ADDI) begin
						res = ea;
					end else if (op == cpu_pkg::OP_LI) begin
						res = sext8(w[7:0]);
					end else begin
						res = m_dmem[ea[cpu_pkg::DMEM_AW-1:0]];
					end
					m_regs[rdf] = res;
					exp_rd.push_back(rdf);
					exp_rdata.push_back(res);
				end
				cpu_pkg::OP_SW: begin
					m_dmem[ea[cpu_pkg::DMEM_AW-1:0]] = m_regs[rdf];
					exp_maddr.push_back(ea[cpu_pkg::DMEM_AW-1:0]);
					exp_mdata.push_back(m_regs[rdf]);
				end
				cpu_pkg::OP_BEQ: begin
					if (m_regs[rdf] == m_regs[rsf]) begin
						npc = mpc + cpu_pkg::XLEN'(1) + sext4(lo);
					end
				end
				cpu_pkg::OP_JMP: begin
					npc = mpc + cpu_pkg::XLEN'(1) + sext12(w[11:0]);
				end
				cpu_pkg::OP_HALT: begin
					done = 1'b1;
				end
				default: begin
					npc = mpc + cpu_pkg::XLEN'(1);
				end
			endcase
			mpc = npc;
			steps++;
		end
		if (!done) begin
			errors++;
			$display("%s: the model never reached the halt instruction", test_name);
		end
	endtask

	// Program goes in while reset is high, then eight more reset cycles
	task automatic load_and_reset();
		logic [cpu_pkg::IMEM_AW-1:0] idx;
		@(posedge clk);
		reset <= 1'b1;
		for (idx = '0; int'(idx) < PROG_LEN; idx++) begin
			@(posedge clk);
			prog_we <= 1'b1;
			prog_addr <= idx;
			prog_data <= prog[idx];
		end
		@(posedge clk);
		prog_we <= 1'b0;
		repeat (RESET_CYCLES) @(posedge clk);
		reset <= 1'b0;
	endtask

	task automatic check_reg_write(
		input logic [cpu_pkg::REG_AW-1:0] rd,
		input logic [cpu_pkg::XLEN-1:0] data
	);
		logic [cpu_pkg::REG_AW-1:0] e_rd;
		logic [cpu_pkg::XLEN-1:0] e_data;
		reg_checks++;
		if (exp_rd.size() == 0) begin
			errors++;
			$display("%s: register write to r%0d with %h when the model expects none",
				test_name, rd, data);
		end else begin
			e_rd = exp_rd.pop_front();
			e_data = exp_rdata.pop_front();
			if (rd !== e_rd || data !== e_data) begin
				errors++;
				$display("ERROR %s reg write: expected r%0d=%h, actual r%0d=%h",
					test_name, e_rd, e_data, rd, data);
			end
		end
	endtask

	task automatic check_mem_write(
		input logic [cpu_pkg::DMEM_AW-1:0] addr,
		input logic [cpu_pkg::XLEN-1:0] data
	);
		logic [cpu_pkg::DMEM_AW-1:0] e_addr;
		logic [cpu_pkg::XLEN-1:0] e_data;
		mem_checks++;
		if (exp_maddr.size() == 0) begin
			errors++;
			$display("%s: store to address %0d with %h when the model expects none",
				test_name, addr, data);
		end else begin
			e_addr = exp_maddr.pop_front();
			e_data = exp_mdata.pop_front();
			if (addr !== e_addr || data !== e_data) begin
				errors++;
				$display("ERROR %s mem write: expected [%0d]=%h, actual [%0d]=%h",
					test_name, e_addr, e_data, addr, data);
			end
		end
	endtask

	// Watch the trace at the falling edge until halted
	task automatic wait_for_halt();
		logic seen;
		int cyc;
		seen = 1'b0;
		cyc = 0;
		while (!seen && cyc < HALT_TIMEOUT) begin
			@(negedge clk);
			cyc++;
			if (wb_en) begin
				check_reg_write(wb_rd, wb_data);
			end
			if (dmem_we) begin
				check_mem_write(dmem_addr, dmem_wdata);
			end
			if (halted) begin
				seen = 1'b1;
			end
		end
		if (!seen) begin
			errors++;
			$display("%s: halted did not rise within %0d cycles", test_name, HALT_TIMEOUT);
		end else begin
			if (exp_rd.size() != 0) begin
				errors++;
				$display("%s: %0d expected register writes never appeared",
					test_name, exp_rd.size());
			end
			if (exp_maddr.size() != 0) begin
				errors++;
				$display("%s: %0d expected stores never appeared",
					test_name, exp_maddr.size());
			end
		end
	endtask

	initial begin
		int p;
		reset <= 1'b1;
		prog_we <= 1'b0;
		prog_addr <= '0;
		prog_data <= '0;
		for (p = 0; p < NUM_PROGS; p++) begin
			test_name = $sformatf("prog%0d", p);
			build_program();
			run_model();
			load_and_reset();
			wait_for_halt();
		end
		errors += dut0.exmem0.asrt0.fail_count;
		$display("Summary: %0d programs, %0d register writes, %0d stores, %0d errors",
			NUM_PROGS, reg_checks, mem_checks, errors);
		if (errors == 0) begin
			$display("All checks passed");
		end else begin
			$display("Checks failed");
		end
		$finish;
	end

endmodule
